//--- hw/dma_pkg.sv
`default_nettype none

package dma_pkg;

  typedef enum logic {
    OP_GET = 1'b0,
    OP_PUT = 1'b1
  } host_op_e;

  // descriptor word 0
  typedef enum logic [31:0] {
    DESC_MEMSET = 32'd0,
    DESC_COPY   = 32'd1
  } dma_op_e;

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_BUSY    = 3'd1,
    ST_DONE    = 3'd2,
    ST_ERROR   = 3'd3, // invalid opcode
    ST_ABORTED = 3'd4
  } dma_status_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_DESC_REQ,
    S_DESC_WAIT,
    S_RD_REQ,
    S_RD_WAIT,
    S_WR_REQ,
    S_WR_WAIT
  } dma_state_e;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dev_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } dev_rsp_t;

  typedef struct packed {
    logic        valid;
    host_op_e    opcode;
    logic [31:0] addr;
    logic [31:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } host_rsp_t;

  typedef struct packed {
    logic        start;
    logic [31:0] desc_addr;
    logic        abort;
  } dma_cmd_t;

  typedef struct packed {
    dma_status_e status;
    logic [31:0] length;
    logic [31:0] src;
    logic [31:0] dst;
  } dma_info_t;

  // device port register map, byte offsets
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_DESC   = 8'h04;
  localparam logic [7:0] REG_STATUS = 8'h08;
  localparam logic [7:0] REG_LENGTH = 8'h0C;
  localparam logic [7:0] REG_SRC    = 8'h10;
  localparam logic [7:0] REG_DST    = 8'h14;

  // descriptor layout, word offsets
  localparam logic [1:0] DESC_W_OP  = 2'd0;
  localparam logic [1:0] DESC_W_LEN = 2'd1;
  localparam logic [1:0] DESC_W_SRC = 2'd2; // pattern for memset
  localparam logic [1:0] DESC_W_DST = 2'd3;

endpackage

`default_nettype wire

//--- hw/dma_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dma_pkg::dev_req_t  dev_req_i,
  output dma_pkg::dev_rsp_t  dev_rsp_o,
  output dma_pkg::dma_cmd_t  cmd_o,
  input  dma_pkg::dma_info_t info_i
);
  import dma_pkg::*;

  logic        wr_en;
  logic        rd_en;
  logic [7:0]  offs;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        rsp_valid_q;
  logic        start_q;
  logic        abort_q;
  logic [31:0] desc_q;

  assign offs  = dev_req_i.addr[7:0]; // upper address bits are not decoded
  assign wr_en = dev_req_i.valid && dev_req_i.write;
  assign rd_en = dev_req_i.valid && !dev_req_i.write;

  always_comb begin
    rdata_d = '0;
    if (rd_en) begin
      case (offs)
        REG_DESC:   rdata_d = desc_q;
        REG_STATUS: rdata_d = {29'b0, info_i.status};
        REG_LENGTH: rdata_d = info_i.length;
        REG_SRC:    rdata_d = info_i.src;
        REG_DST:    rdata_d = info_i.dst;
        default:    rdata_d = '0; // ctrl and unmapped
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      start_q     <= 1'b0;
      abort_q     <= 1'b0;
      desc_q      <= '0;
    end else begin
      rsp_valid_q <= dev_req_i.valid; // reads and writes both answered
      start_q     <= 1'b0;
      abort_q     <= 1'b0;
      if (wr_en && offs == REG_DESC) begin
        start_q <= 1'b1;
        desc_q  <= dev_req_i.wdata;
      end
      if (wr_en && offs == REG_CTRL && dev_req_i.wdata[0]) begin
        abort_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign dev_rsp_o = '{valid: rsp_valid_q, rdata: rdata_q};

  // desc_addr lands on the same edge as the start pulse
  assign cmd_o = '{start: start_q, desc_addr: desc_q, abort: abort_q};

  // the master leaves a gap cycle after every access
  a_req_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dev_req_i.valid |=> !dev_req_i.valid);

endmodule

`default_nettype wire

//--- hw/dma_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dma_pkg::dma_cmd_t  cmd_i,
  output dma_pkg::dma_info_t info_o,
  output dma_pkg::host_req_t host_req_o,
  input  logic               host_ready_i,
  input  dma_pkg::host_rsp_t host_rsp_i
);
  import dma_pkg::*;

  dma_state_e  state_q;
  dma_status_e status_q;
  logic [1:0]  word_q;
  logic        pending_q;
  logic [31:0] len_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] desc_addr_q;
  dma_op_e     op_q;
  logic [31:0] rdata_q;

  logic        req_state;
  logic        hs;
  logic        op_ok;
  logic        last_word;
  logic [31:0] len_next;

  assign req_state = (state_q == S_DESC_REQ) || (state_q == S_RD_REQ) ||
                     (state_q == S_WR_REQ);
  assign hs        = host_req_o.valid && host_ready_i;
  assign op_ok     = (op_q == DESC_MEMSET) || (op_q == DESC_COPY);
  assign last_word = (len_q <= 32'd4);
  assign len_next  = last_word ? '0 : len_q - 32'd4;

  // request is built from registers only, so it holds while ready is low
  always_comb begin
    host_req_o.valid  = req_state && !pending_q; // wait out a stale response
    host_req_o.opcode = OP_GET;
    host_req_o.addr   = src_q;
    host_req_o.wdata  = '0;
    case (state_q)
      S_DESC_REQ: begin
        host_req_o.addr = desc_addr_q + {28'b0, word_q, 2'b00};
      end
      S_WR_REQ: begin
        host_req_o.opcode = OP_PUT;
        host_req_o.addr   = dst_q;
        host_req_o.wdata  = (op_q == DESC_COPY) ? rdata_q : src_q;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= S_IDLE;
      status_q  <= ST_IDLE;
      word_q    <= '0;
      pending_q <= 1'b0;
      len_q     <= '0;
      src_q     <= '0;
      dst_q     <= '0;
    end else begin
      if (hs) begin
        pending_q <= 1'b1;
      end else if (host_rsp_i.valid) begin
        pending_q <= 1'b0;
      end

      if (cmd_i.abort && state_q != S_IDLE) begin
        state_q  <= S_IDLE;
        status_q <= ST_ABORTED;
      end else begin
        case (state_q)
          S_IDLE: begin
            if (cmd_i.start) begin
              state_q  <= S_DESC_REQ;
              status_q <= ST_BUSY;
              word_q   <= '0;
            end
          end
          S_DESC_REQ: begin
            if (hs) state_q <= S_DESC_WAIT;
          end
          S_DESC_WAIT: begin
            if (host_rsp_i.valid) begin
              case (word_q)
                DESC_W_LEN: len_q <= host_rsp_i.rdata;
                DESC_W_SRC: src_q <= host_rsp_i.rdata;
                DESC_W_DST: dst_q <= host_rsp_i.rdata;
                default: begin // opcode goes to op_q
                end
              endcase
              if (word_q == DESC_W_DST) begin
                // opcode and length are already captured here
                if (!op_ok) begin
                  state_q  <= S_IDLE;
                  status_q <= ST_ERROR;
                end else if (len_q == '0) begin
                  state_q  <= S_IDLE;
                  status_q <= ST_DONE;
                end else if (op_q == DESC_COPY) begin
                  state_q <= S_RD_REQ;
                end else begin
                  state_q <= S_WR_REQ;
                end
              end else begin
                word_q  <= word_q + 2'd1;
                state_q <= S_DESC_REQ;
              end
            end
          end
          S_RD_REQ: begin
            if (hs) state_q <= S_RD_WAIT;
          end
          S_RD_WAIT: begin
            if (host_rsp_i.valid) state_q <= S_WR_REQ;
          end
          S_WR_REQ: begin
            if (hs) state_q <= S_WR_WAIT;
          end
          S_WR_WAIT: begin
            if (host_rsp_i.valid) begin
              len_q <= len_next;
              dst_q <= dst_q + 32'd4;
              if (op_q == DESC_COPY) src_q <= src_q + 32'd4; // memset keeps pattern
              if (last_word) begin
                state_q  <= S_IDLE;
                status_q <= ST_DONE;
              end else if (op_q == DESC_COPY) begin
                state_q <= S_RD_REQ;
              end else begin
                state_q <= S_WR_REQ;
              end
            end
          end
          default: begin
            state_q <= S_IDLE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && cmd_i.start) begin
      desc_addr_q <= cmd_i.desc_addr;
    end
    if (state_q == S_DESC_WAIT && host_rsp_i.valid && word_q == DESC_W_OP) begin
      op_q <= dma_op_e'(host_rsp_i.rdata);
    end
    if (state_q == S_RD_WAIT && host_rsp_i.valid) begin
      rdata_q <= host_rsp_i.rdata; // copy data for the next put
    end
  end

  assign info_o = '{status: status_q, length: len_q, src: src_q, dst: dst_q};

  // stalled request must not change until the handshake
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_req_o.valid && !host_ready_i && !cmd_i.abort |=> $stable(host_req_o));

  // responses only for a request that went out
  a_no_stray_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp_i.valid |-> pending_q);

  // status reports busy exactly while a job runs
  a_busy_matches_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == S_IDLE) == (status_q != ST_BUSY));

endmodule

`default_nettype wire

//--- hw/dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  dma_pkg::dev_req_t  dev_req_i,
  output dma_pkg::dev_rsp_t  dev_rsp_o,

  output dma_pkg::host_req_t host_req_o,
  input  logic               host_ready_i,
  input  dma_pkg::host_rsp_t host_rsp_i
);
  import dma_pkg::*;

  dma_cmd_t  cmd;  // start and abort pulses
  dma_info_t info;

  dma_regs u_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .dev_req_i (dev_req_i),
    .dev_rsp_o (dev_rsp_o),
    .cmd_o     (cmd),
    .info_i    (info)
  );

  dma_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd),
    .info_o       (info),
    .host_req_o   (host_req_o),
    .host_ready_i (host_ready_i),
    .host_rsp_i   (host_rsp_i)
  );

endmodule

`default_nettype wire

//--- tb/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dma_pkg::host_req_t host_req_i,
  output logic               host_ready_o,
  output dma_pkg::host_rsp_t host_rsp_o
);
  import dma_pkg::*;

  logic [31:0] mem [0:1023]; // word array, byte address bits 11:2
  logic [31:0] lcg_q;
  logic        busy_q;
  logic [1:0]  wait_q;
  logic        rsp_valid_q;
  logic [31:0] data_q = '0;
  logic [9:0]  idx;
  logic        hs;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  assign idx = host_req_i.addr[11:2];
  assign hs  = host_req_i.valid && host_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lcg_q        <= 32'd34426;
      host_ready_o <= 1'b0;
      busy_q       <= 1'b0;
      wait_q       <= '0;
      rsp_valid_q  <= 1'b0;
    end else begin
      lcg_q        <= lcg_step(lcg_q);
      host_ready_o <= (lcg_q[31:24] < 8'd179); // high on about 70% of cycles
      rsp_valid_q  <= 1'b0;
      if (hs) begin
        busy_q <= 1'b1;
        wait_q <= (lcg_q[20:19] == 2'd3) ? 2'd1 : lcg_q[20:19]; // answer 1 to 3 cycles later
      end else if (busy_q) begin
        if (wait_q == 2'd0) begin
          rsp_valid_q <= 1'b1;
          busy_q      <= 1'b0;
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

  // writes land at the handshake
  always @(posedge clk_i) begin
    if (hs) begin
      if (host_req_i.opcode == OP_PUT) begin
        mem[idx] = host_req_i.wdata;
      end else begin
        data_q <= mem[idx];
      end
    end
  end

  assign host_rsp_o = '{valid: rsp_valid_q, rdata: data_q};

endmodule

`default_nettype wire

//--- tb/dma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dma_tb;
  import dma_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000; // scenario words times 10 cycles, plus margin

  logic        clk = 1'b0;
  logic        rst_n;
  dev_req_t    dev_req;
  dev_rsp_t    dev_rsp;
  host_req_t   host_req;
  host_rsp_t   host_rsp;
  logic        host_ready;
  int          cycles = 0;
  logic [31:0] rng;
  logic [31:0] src_data [0:23];
  logic [31:0] image [0:1023];

  dma_top u_dma_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .dev_req_i    (dev_req),
    .dev_rsp_o    (dev_rsp),
    .host_req_o   (host_req),
    .host_ready_i (host_ready),
    .host_rsp_i   (host_rsp)
  );

  mem_model u_mem (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .host_req_i   (host_req),
    .host_ready_o (host_ready),
    .host_rsp_o   (host_rsp)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      fail_run();
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return {~idx[15:0], idx[15:0]}; // differs for every word index
  endfunction

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run();
    end
  endtask

  // one access, answer sampled mid-cycle after it lands
  task automatic dev_access(input logic is_write, input logic [7:0] offs,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    dev_req <= '{valid: 1'b1, write: is_write, addr: {24'h0, offs}, wdata: wdata};
    @(posedge clk);
    dev_req <= '0;
    @(negedge clk);
    assert (dev_rsp.valid) else begin
      $display("no device response for the access at offset 0x%h", offs);
      fail_run();
    end
    rdata = dev_rsp.rdata;
  endtask

  task automatic write_reg(input logic [7:0] offs, input logic [31:0] wdata);
    logic [31:0] rdata;
    dev_access(1'b1, offs, wdata, rdata);
    expect_eq("dev_rsp.rdata", rdata, 32'h0);
  endtask

  task automatic read_reg(input logic [7:0] offs, output logic [31:0] rdata);
    dev_access(1'b0, offs, 32'h0, rdata);
  endtask

  task automatic wait_not_busy(output logic [31:0] status);
    read_reg(REG_STATUS, status);
    while (status == 32'(ST_BUSY)) begin
      read_reg(REG_STATUS, status);
    end
  endtask

  task automatic run_job(input logic [31:0] desc_addr, input dma_status_e exp);
    logic [31:0] status;
    write_reg(REG_DESC, desc_addr);
    wait_not_busy(status);
    expect_eq("status", status, 32'(exp));
  endtask

  task automatic expect_regs(input logic [31:0] src, input logic [31:0] dst);
    logic [31:0] rd;
    read_reg(REG_LENGTH, rd);
    expect_eq("length", rd, 32'h0);
    read_reg(REG_SRC, rd);
    expect_eq("src", rd, src);
    read_reg(REG_DST, rd);
    expect_eq("dst", rd, dst);
  endtask

  task automatic place_desc(input int addr, input logic [31:0] op, input logic [31:0] len,
                            input logic [31:0] src, input logic [31:0] dst);
    u_mem.mem[addr / 4 + DESC_W_OP]  = op;
    u_mem.mem[addr / 4 + DESC_W_LEN] = len;
    u_mem.mem[addr / 4 + DESC_W_SRC] = src;
    u_mem.mem[addr / 4 + DESC_W_DST] = dst;
  endtask

  task automatic check_pattern(input int base, input int words, input logic [31:0] pattern);
    for (int k = 0; k < words; k++) begin
      expect_eq($sformatf("mem[%0d]", base + k), u_mem.mem[base + k], pattern);
    end
  endtask

  task automatic check_copy(input int dst_base, input int words);
    for (int k = 0; k < words; k++) begin
      expect_eq($sformatf("mem[%0d]", dst_base + k), u_mem.mem[dst_base + k], src_data[k]);
      expect_eq($sformatf("mem[%0d]", 384 + k), u_mem.mem[384 + k], src_data[k]);
    end
  endtask

  task automatic save_image();
    for (int i = 0; i < 1024; i++) begin
      image[i] = u_mem.mem[i];
    end
  endtask

  task automatic check_unchanged();
    for (int i = 0; i < 1024; i++) begin
      expect_eq($sformatf("mem[%0d]", i), u_mem.mem[i], image[i]);
    end
  endtask

  initial begin
    logic [31:0] rd;
    int          written;
    rst_n   = 1'b0;
    dev_req = '0;
    rng     = 32'd34426;
    for (int i = 0; i < 1024; i++) begin
      u_mem.mem[i] = fill_word(i);
    end
    for (int k = 0; k < 24; k++) begin // copy source at 0x600
      rng                = lcg_next(rng);
      src_data[k]        = rng;
      u_mem.mem[384 + k] = rng;
    end
    place_desc('h00, DESC_MEMSET, 64, 32'hA5A5_5A5A, 'h400);
    place_desc('h10, DESC_COPY, 96, 'h600, 'h800);
    place_desc('h20, DESC_MEMSET, 0, 32'h1111_1111, 'h900);
    place_desc('h30, 32'd7, 16, 'h600, 'h900);
    place_desc('h40, DESC_MEMSET, 1024, 32'h5A5A_A5A5, 'hC00);
    place_desc('h50, DESC_MEMSET, 32, 32'h1234_5678, 'h480);
    place_desc('h60, DESC_COPY, 80, 'h600, 'hA00);
    place_desc('h70, DESC_MEMSET, 32, 32'h0BAD_F00D, 'hB00);

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    read_reg(REG_STATUS, rd);
    expect_eq("status", rd, 32'(ST_IDLE));

    run_job(32'h00, ST_DONE);
    check_pattern(256, 16, 32'hA5A5_5A5A);
    expect_eq("mem[255]", u_mem.mem[255], fill_word(255)); // guards around the region
    expect_eq("mem[272]", u_mem.mem[272], fill_word(272));
    expect_regs(32'hA5A5_5A5A, 32'h400 + 32'd64);

    run_job(32'h10, ST_DONE);
    check_copy(512, 24);
    expect_regs(32'h600 + 32'd96, 32'h800 + 32'd96);

    save_image();
    run_job(32'h20, ST_DONE);
    check_unchanged();
    run_job(32'h30, ST_ERROR);
    check_unchanged();

    write_reg(REG_DESC, 32'h40);
    repeat (40) @(posedge clk);
    write_reg(REG_CTRL, 32'h1);
    wait_not_busy(rd);
    expect_eq("status", rd, 32'(ST_ABORTED));
    written = 0;
    while (written < 256 && u_mem.mem[768 + written] === 32'h5A5A_A5A5) begin
      written++;
    end
    assert (written < 256) else begin
      $display("abort did not stop the memset before the end of its region");
      fail_run();
    end
    for (int k = written; k < 256; k++) begin
      expect_eq($sformatf("mem[%0d]", 768 + k), u_mem.mem[768 + k], fill_word(768 + k));
    end
    run_job(32'h50, ST_DONE);
    check_pattern(288, 8, 32'h1234_5678);
    expect_regs(32'h1234_5678, 32'h480 + 32'd32);

    write_reg(REG_DESC, 32'h60);
    repeat (10) @(posedge clk);
    read_reg(REG_STATUS, rd);
    expect_eq("status", rd, 32'(ST_BUSY));
    run_job(32'h70, ST_DONE); // lands while the copy runs
    check_copy(640, 20);
    expect_eq("mem[660]", u_mem.mem[660], fill_word(660));
    for (int k = 704; k < 712; k++) begin
      expect_eq($sformatf("mem[%0d]", k), u_mem.mem[k], fill_word(k));
    end
    expect_regs(32'h600 + 32'd80, 32'hA00 + 32'd80);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/dma_pkg.sv
hw/dma_regs.sv
hw/dma_ctrl.sv
hw/dma_top.sv
tb/mem_model.sv
tb/dma_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module dma_tb -f filelist.f -o dma_sim

status=0
./obj_dir/dma_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run failed"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
grep -q "Simulation completed successfully" sim.log
